//--- hw/bus_cfg.svh
// Build-time sizes of the bus subsystem, included by the package and by every RTL file
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// Address and data bus widths in bits
`define BUS_ADDR_WIDTH 32
`define BUS_DATA_WIDTH 32

// Number of register banks behind the decoder, one per target index
`define BUS_NUM_TARGETS 4

// Number of range rules in the run-time address map
`define BUS_NUM_RULES 5

// Bank geometry, with the word offset taken from address bits [4:2]
`define BUS_BANK_WORDS 8
`define BUS_OFS_LSB 2
`define BUS_OFS_BITS 3

// Width of the saturating decode-error counter
`define BUS_ERR_CNT_WIDTH 16

`endif

//--- hw/bus_pkg.sv
// Shared types of the bus subsystem, imported by each RTL module and by the testbench
`include "bus_cfg.svh"

package bus_pkg;

  // Plain vectors for the widths that carry a meaning on the bus
  typedef logic [`BUS_ADDR_WIDTH-1:0]          addr_t;
  typedef logic [`BUS_DATA_WIDTH-1:0]          data_t;
  typedef logic [$clog2(`BUS_NUM_TARGETS)-1:0] tgt_idx_t;
  typedef logic [`BUS_OFS_BITS-1:0]            word_ofs_t;
  typedef logic [`BUS_ERR_CNT_WIDTH-1:0]       err_cnt_t;

  // One entry of the address map
  // The range is [start_addr, end_addr), and an end_addr of zero runs to the top
  typedef struct packed {
    tgt_idx_t idx;
    addr_t    start_addr;
    addr_t    end_addr;
  } rule_t;

  // Request as issued by the master, qualified by a separate strobe
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
  } bus_req_t;

  // Request after the decode stage
  // The address is reduced to the target index and the word offset in that bank
  typedef struct packed {
    logic      we;
    data_t     wdata;
    word_ofs_t ofs;
    tgt_idx_t  idx;
    logic      dec_err;
  } dec_req_t;

  // Result handed from the execute stage to the result stage
  typedef struct packed {
    logic  we;
    logic  dec_err;
    data_t rdata;
  } exec_rsp_t;

  // Response returned to the master
  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

endpackage

//--- hw/addr_decode.sv
// Combinational address-range decoder that maps an address to a target index via a rule array
`timescale 1ns/10ps

module addr_decode #(
  // Number of rules in the address map
  parameter int unsigned NoRules = 1,
  // Rule struct with the fields idx, start_addr and end_addr
  parameter type         rule_t  = logic,
  // Address type used by the rules and by the decoded address
  parameter type         addr_t  = logic,
  // Target index type
  parameter type         idx_t   = logic
) (
  input  addr_t               addr_i,
  input  rule_t [NoRules-1:0] addr_map_i,
  input  logic                en_default_idx_i,
  input  idx_t                default_idx_i,
  output idx_t                idx_o,
  output logic                dec_valid_o,
  output logic                dec_error_o
);

  always_comb begin
    // With no match the result falls back to the default index when it is enabled
    // Without the default an unmatched address reports an error on index zero
    idx_o       = en_default_idx_i ? default_idx_i : idx_t'(0);
    dec_valid_o = 1'b0;
    dec_error_o = ~en_default_idx_i;

    // Scanning upward lets a later match overwrite an earlier one
    // This gives the rule at the higher array position priority on overlap
    for (int unsigned i = 0; i < NoRules; i++) begin
      // Start is inclusive and end is exclusive
      // An end of zero stands for the top of the address space
      if ((addr_i >= addr_map_i[i].start_addr) &&
          ((addr_i < addr_map_i[i].end_addr) || (addr_map_i[i].end_addr == '0))) begin
        idx_o       = idx_t'(addr_map_i[i].idx);
        dec_valid_o = 1'b1;
        dec_error_o = 1'b0;
      end
    end
  end

endmodule

//--- hw/req_decode_stage.sv
// First pipeline stage that decodes each incoming request and registers it for the execute stage
`timescale 1ns/10ps
`include "bus_cfg.svh"

module req_decode_stage (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  // Incoming request from the master
  input  logic                                   req_valid_i,
  input  bus_pkg::bus_req_t                      req_i,
  // Run-time address map and default target
  input  bus_pkg::rule_t [`BUS_NUM_RULES-1:0]    addr_map_i,
  input  logic                                   en_default_idx_i,
  input  bus_pkg::tgt_idx_t                      default_idx_i,
  // Decoded request towards the execute stage
  output logic                                   dec_valid_o,
  output bus_pkg::dec_req_t                      dec_req_o
);

  import bus_pkg::*;

  // Combinational decode results for the request in this cycle
  tgt_idx_t  dec_idx;
  logic      dec_error;
  word_ofs_t word_ofs;

  // Registered strobe and payload
  logic      valid_q;
  dec_req_t  req_q;

  // The decoder sees the raw address and the current map
  // Its valid flag is the inverse of the error flag when the default is off, so it stays open
  addr_decode #(
    .NoRules (`BUS_NUM_RULES),
    .rule_t  (rule_t),
    .addr_t  (addr_t),
    .idx_t   (tgt_idx_t)
  ) u_addr_decode (
    .addr_i           (req_i.addr),
    .addr_map_i       (addr_map_i),
    .en_default_idx_i (en_default_idx_i),
    .default_idx_i    (default_idx_i),
    .idx_o            (dec_idx),
    .dec_valid_o      (),
    .dec_error_o      (dec_error)
  );

  // Word offset within the bank, taken above the byte offset
  assign word_ofs = req_i.addr[`BUS_OFS_LSB +: `BUS_OFS_BITS];

  // Only the strobe is cleared by reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_valid_i;
    end
  end

  // The payload is captured every cycle and is qualified by the strobe
  always_ff @(posedge clk_i) begin
    req_q.we      <= req_i.we;
    req_q.wdata   <= req_i.wdata;
    req_q.ofs     <= word_ofs;
    req_q.idx     <= dec_idx;
    req_q.dec_err <= dec_error;
  end

  assign dec_valid_o = valid_q;
  assign dec_req_o   = req_q;

endmodule

//--- hw/target_bank_exec.sv
// Execute stage that holds the register banks of all targets and performs reads and writes
`timescale 1ns/10ps
`include "bus_cfg.svh"

module target_bank_exec (
  input  logic               clk_i,
  input  logic               rst_i,
  // Decoded request from the decode stage
  input  logic               dec_valid_i,
  input  bus_pkg::dec_req_t  dec_req_i,
  // Executed result towards the result stage
  output logic               exec_valid_o,
  output bus_pkg::exec_rsp_t exec_rsp_o
);

  import bus_pkg::*;

  // Storage of every bank, indexed by target and word offset
  data_t     bank_q [`BUS_NUM_TARGETS][`BUS_BANK_WORDS];

  // An access only touches a bank when it is valid and the address decoded cleanly
  logic      access;
  logic      do_write;
  logic      do_read;

  // Registered strobe and result
  logic      valid_q;
  exec_rsp_t rsp_q;

  assign access   = dec_valid_i & ~dec_req_i.dec_err;
  assign do_write = access & dec_req_i.we;
  assign do_read  = access & ~dec_req_i.we;

  // Bank contents start out as zero
  // A write lands on the edge that closes this stage, so a read one cycle later sees it
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int t = 0; t < `BUS_NUM_TARGETS; t++) begin
        for (int w = 0; w < `BUS_BANK_WORDS; w++) begin
          bank_q[t][w] <= '0;
        end
      end
    end else if (do_write) begin
      bank_q[dec_req_i.idx][dec_req_i.ofs] <= dec_req_i.wdata;
    end
  end

  // Strobe of the result, cleared on reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= dec_valid_i;
    end
  end

  // Read data is registered together with the flags that travel alongside it
  // Anything other than a clean read returns zero data
  always_ff @(posedge clk_i) begin
    rsp_q.we      <= dec_req_i.we;
    rsp_q.dec_err <= dec_req_i.dec_err;
    if (do_read) begin
      rsp_q.rdata <= bank_q[dec_req_i.idx][dec_req_i.ofs];
    end else begin
      rsp_q.rdata <= '0;
    end
  end

  assign exec_valid_o = valid_q;
  assign exec_rsp_o   = rsp_q;

endmodule

//--- hw/rsp_result_stage.sv
// Result stage that forms the registered bus response and counts decode errors
`timescale 1ns/10ps

module rsp_result_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  // Executed result from the execute stage
  input  logic               exec_valid_i,
  input  bus_pkg::exec_rsp_t exec_rsp_i,
  // Response to the master
  output logic               rsp_valid_o,
  output bus_pkg::bus_rsp_t  rsp_o,
  // Number of decode errors seen since reset
  output bus_pkg::err_cnt_t  err_count_o
);

  import bus_pkg::*;

  // Response formed from the executed result
  bus_rsp_t rsp_d;

  // Registered strobe, response and counter
  logic     valid_q;
  bus_rsp_t rsp_q;
  err_cnt_t err_cnt_q;

  // Read data goes back only for reads that decoded cleanly
  always_comb begin
    rsp_d.err   = exec_rsp_i.dec_err;
    rsp_d.rdata = (!exec_rsp_i.we && !exec_rsp_i.dec_err) ? exec_rsp_i.rdata : '0;
  end

  // The counter sticks at all ones rather than wrapping around
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q   <= 1'b0;
      err_cnt_q <= '0;
    end else begin
      valid_q <= exec_valid_i;
      if (exec_valid_i && exec_rsp_i.dec_err && (err_cnt_q != '1)) begin
        err_cnt_q <= err_cnt_q + err_cnt_t'(1);
      end
    end
  end

  // The last response is held between strobes
  always_ff @(posedge clk_i) begin
    if (exec_valid_i) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_o       = rsp_q;
  assign err_count_o = err_cnt_q;

endmodule

//--- hw/bus_demux_top.sv
// Top level of the bus subsystem that chains the decode, execute and result stages
`timescale 1ns/10ps
`include "bus_cfg.svh"

module bus_demux_top (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Request from the master, one per cycle at most
  input  logic                                req_valid_i,
  input  bus_pkg::bus_req_t                   req_i,
  // Run-time address map and default target
  input  bus_pkg::rule_t [`BUS_NUM_RULES-1:0] addr_map_i,
  input  logic                                en_default_idx_i,
  input  bus_pkg::tgt_idx_t                   default_idx_i,
  // Response three cycles after its request
  output logic                                rsp_valid_o,
  output bus_pkg::bus_rsp_t                   rsp_o,
  output bus_pkg::err_cnt_t                   err_count_o
);

  import bus_pkg::*;

  // Strobe and payload between decode and execute
  logic      dec_valid;
  dec_req_t  dec_req;

  // Strobe and payload between execute and result
  logic      exec_valid;
  exec_rsp_t exec_rsp;

  // Stage one registers the request with its target index and word offset
  req_decode_stage u_req_decode_stage (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_valid_i      (req_valid_i),
    .req_i            (req_i),
    .addr_map_i       (addr_map_i),
    .en_default_idx_i (en_default_idx_i),
    .default_idx_i    (default_idx_i),
    .dec_valid_o      (dec_valid),
    .dec_req_o        (dec_req)
  );

  // Stage two accesses the selected bank
  target_bank_exec u_target_bank_exec (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .dec_valid_i  (dec_valid),
    .dec_req_i    (dec_req),
    .exec_valid_o (exec_valid),
    .exec_rsp_o   (exec_rsp)
  );

  // Stage three forms the response and counts decode errors
  rsp_result_stage u_rsp_result_stage (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .exec_valid_i (exec_valid),
    .exec_rsp_i   (exec_rsp),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o),
    .err_count_o  (err_count_o)
  );

endmodule

//--- testbench/tb_bus_demux.sv
// Self-checking testbench for bus_demux_top that applies a stimulus table and checks responses
`timescale 1ns/10ps
`include "bus_cfg.svh"

module tb_bus_demux;

  import bus_pkg::*;

  localparam int NUM_STIM = 26;

  // One table row is one request, issued on consecutive cycles
  typedef struct packed {
    addr_t    addr;
    logic     we;
    logic     use_rand;
    logic     en_def;
    tgt_idx_t def_idx;
  } stim_t;

  // Expected response together with the cycle its request was driven in
  typedef struct packed {
    int       entry;
    int       cyc;
    bus_rsp_t rsp;
    err_cnt_t cnt;
  } exp_t;

  logic                             clk_i = 1'b0;
  logic                             rst_i;
  logic                             req_valid_i;
  bus_req_t                         req_i;
  rule_t [`BUS_NUM_RULES-1:0]       addr_map;
  logic                             en_default_idx_i;
  tgt_idx_t                         default_idx_i;
  logic                             rsp_valid_o;
  bus_rsp_t                         rsp_o;
  err_cnt_t                         err_count_o;

  stim_t     stim_tab [NUM_STIM];
  int        stim_cnt = 0;
  exp_t      exp_q [$];
  data_t     model_bank [`BUS_NUM_TARGETS][`BUS_BANK_WORDS];
  err_cnt_t  model_err;
  logic [31:0] lfsr_q = 32'h257c_0228;
  int        cycle_q = 0;
  int        checked = 0;
  int        rsp_errs = 0;
  int        cnt_errs = 0;
  int        other_errs = 0;

  bus_demux_top DUT (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_valid_i      (req_valid_i),
    .req_i            (req_i),
    .addr_map_i       (addr_map),
    .en_default_idx_i (en_default_idx_i),
    .default_idx_i    (default_idx_i),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_o            (rsp_o),
    .err_count_o      (err_count_o)
  );

  // 20 ns clock period
  always #10 clk_i = ~clk_i;

  // Cycle count for the latency check, stable by the falling edge
  always @(posedge clk_i) cycle_q <= cycle_q + 1;

  // Taps 32, 22, 2 and 1 give a maximal-length sequence
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per data bit
  task automatic next_rand(output data_t w);
    w = '0;
    for (int b = 0; b < `BUS_DATA_WIDTH; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w = {w[`BUS_DATA_WIDTH-2:0], lfsr_q[0]};
    end
  endtask

  task automatic add_stim(input addr_t a, input logic we, input logic rnd,
                          input logic en, input tgt_idx_t di);
    stim_tab[stim_cnt] = '{addr: a, we: we, use_rand: rnd, en_def: en, def_idx: di};
    stim_cnt++;
  endtask

  // Reference decode searches from the highest rule down and takes the first hit
  task automatic model_decode(input addr_t a, input logic en, input tgt_idx_t di,
                              output tgt_idx_t idx, output logic err);
    logic found;
    found = 1'b0;
    idx   = '0;
    for (int r = `BUS_NUM_RULES - 1; r >= 0; r--) begin
      if (!found && a >= addr_map[r].start_addr &&
          (addr_map[r].end_addr == '0 || a < addr_map[r].end_addr)) begin
        found = 1'b1;
        idx   = addr_map[r].idx;
      end
    end
    if (!found && en) begin
      idx = di;
    end
    err = !found && !en;
  endtask

  task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input int entry);
    if (got !== exp) begin
      rsp_errs++;
      $display("CHECK FAILED at %0t: entry %0d rdata=%h err=%b, expected rdata=%h err=%b",
               $time, entry, got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  task automatic check_err_count(input err_cnt_t got, input err_cnt_t exp, input string what);
    if (got !== exp) begin
      cnt_errs++;
      $display("CHECK FAILED at %0t: %s error count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Responses are sampled on the falling edge, away from the DUT's register updates
  always @(negedge clk_i) begin : monitor
    exp_t e;
    if (rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("Unexpected response at %0t with no request outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        checked++;
        if (cycle_q - e.cyc != 3) begin
          other_errs++;
          $display("Entry %0d responded after %0d cycles instead of 3", e.entry, cycle_q - e.cyc);
        end
        check_rsp(rsp_o, e.rsp, e.entry);
        check_err_count(err_count_o, e.cnt, $sformatf("entry %0d", e.entry));
      end
    end
  end

  // Budget of one cycle per table row plus margin for reset and draining
  initial begin : watchdog
    #((NUM_STIM + 20) * 20);
    $display("Timeout: the run did not finish within %0d ns", (NUM_STIM + 20) * 20);
    $display("Test failures found");
    $finish;
  end

  initial begin : stimulus
    stim_t    s;
    data_t    wd;
    exp_t     e;
    tgt_idx_t idx;
    logic     derr;
    word_ofs_t ofs;

    rst_i            = 1'b1;
    req_valid_i      = 1'b0;
    req_i            = '0;
    en_default_idx_i = 1'b0;
    default_idx_i    = '0;
    model_err        = '0;
    for (int t = 0; t < `BUS_NUM_TARGETS; t++) begin
      for (int w = 0; w < `BUS_BANK_WORDS; w++) begin
        model_bank[t][w] = '0;
      end
    end

    // Rule 3 sits inside rule 1 and wins there
    // Rule 4 is open to the top of the address space
    addr_map[0] = '{idx: 2'd0, start_addr: 32'h0000_1000, end_addr: 32'h0000_1020};
    addr_map[1] = '{idx: 2'd1, start_addr: 32'h0000_2000, end_addr: 32'h0000_2020};
    addr_map[2] = '{idx: 2'd2, start_addr: 32'h0000_3000, end_addr: 32'h0000_3020};
    addr_map[3] = '{idx: 2'd3, start_addr: 32'h0000_2010, end_addr: 32'h0000_2018};
    addr_map[4] = '{idx: 2'd3, start_addr: 32'hF000_0000, end_addr: 32'h0000_0000};

    // Write each bank, then read it back
    add_stim(32'h0000_1000, 1'b1, 1'b1, 1'b0, 2'd0);
    add_stim(32'h0000_2004, 1'b1, 1'b1, 1'b0, 2'd0);
    add_stim(32'h0000_3008, 1'b1, 1'b1, 1'b0, 2'd0);
    add_stim(32'h0000_2014, 1'b1, 1'b1, 1'b0, 2'd0);
    add_stim(32'h0000_1000, 1'b0, 1'b0, 1'b0, 2'd0);
    add_stim(32'h0000_2004, 1'b0, 1'b0, 1'b0, 2'd0);
    add_stim(32'h0000_3008, 1'b0, 1'b0, 1'b0, 2'd0);
    add_stim(32'h0000_2014, 1'b0, 1'b0, 1'b0, 2'd0);
    // Bank 3 seen through the open window
    // Bank 1 word 1 must not show up here
    add_stim(32'hF000_0014, 1'b0, 1'b0, 1'b0, 2'd0);
    add_stim(32'hF000_0004, 1'b0, 1'b0, 1'b0, 2'd0);
    add_stim(32'hF000_0008, 1'b1, 1'b1, 1'b0, 2'd0);
    add_stim(32'hF000_0008, 1'b0, 1'b0, 1'b0, 2'd0);
    add_stim(32'h0000_2018, 1'b0, 1'b0, 1'b0, 2'd0);
    // Unmapped with the default off gives errors and leaves bank 0 alone
    add_stim(32'h0000_5000, 1'b1, 1'b1, 1'b0, 2'd0);
    add_stim(32'h0000_5000, 1'b0, 1'b0, 1'b0, 2'd0);
    add_stim(32'h0000_1000, 1'b0, 1'b0, 1'b0, 2'd0);
    // Default on to bank 2, then back-to-back traffic on one word
    add_stim(32'h0000_5004, 1'b1, 1'b1, 1'b1, 2'd2);
    add_stim(32'h0000_5004, 1'b0, 1'b0, 1'b1, 2'd2);
    add_stim(32'h0000_3004, 1'b0, 1'b0, 1'b1, 2'd2);
    add_stim(32'h0000_1010, 1'b1, 1'b1, 1'b1, 2'd2);
    add_stim(32'h0000_1010, 1'b0, 1'b0, 1'b1, 2'd2);
    add_stim(32'h0000_1010, 1'b1, 1'b0, 1'b1, 2'd2);
    add_stim(32'h0000_1010, 1'b0, 1'b0, 1'b1, 2'd2);
    add_stim(32'h0000_5018, 1'b1, 1'b1, 1'b1, 2'd2);
    add_stim(32'h0000_3018, 1'b0, 1'b0, 1'b1, 2'd2);
    add_stim(32'h0000_6000, 1'b0, 1'b0, 1'b0, 2'd0);

    repeat (2) @(posedge clk_i);
    #2 rst_i = 1'b0;

    @(negedge clk_i);
    if (rsp_valid_o !== 1'b0) begin
      other_errs++;
      $display("Response strobe is not low after reset");
    end
    check_err_count(err_count_o, '0, "after reset");

    for (int n = 0; n < NUM_STIM; n++) begin
      @(posedge clk_i);
      #2;
      s = stim_tab[n];
      if (s.use_rand) begin
        next_rand(wd);
      end else begin
        wd = ~s.addr;
      end
      req_valid_i      = 1'b1;
      req_i            = '{addr: s.addr, we: s.we, wdata: wd};
      en_default_idx_i = s.en_def;
      default_idx_i    = s.def_idx;

      // The model runs in request order, so a read after a write sees the new word
      model_decode(s.addr, s.en_def, s.def_idx, idx, derr);
      ofs = s.addr[`BUS_OFS_LSB +: `BUS_OFS_BITS];
      e.entry     = n;
      e.cyc       = cycle_q;
      e.rsp.rdata = '0;
      e.rsp.err   = derr;
      if (derr) begin
        if (model_err != '1) begin
          model_err = model_err + err_cnt_t'(1);
        end
      end else if (s.we) begin
        model_bank[idx][ofs] = wd;
      end else begin
        e.rsp.rdata = model_bank[idx][ofs];
      end
      e.cnt = model_err;
      exp_q.push_back(e);
    end

    @(posedge clk_i);
    #2 req_valid_i = 1'b0;

    // The last response is due three cycles after its request, so a few edges suffice
    for (int k = 0; k < 5 && exp_q.size() != 0; k++) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
    check_err_count(err_count_o, model_err, "final");
    if (checked != NUM_STIM) begin
      other_errs++;
      $display("Only %0d of %0d responses arrived", checked, NUM_STIM);
    end

    $display("Summary: %0d checked, %0d response errors, %0d count errors, %0d other errors",
             checked, rsp_errs, cnt_errs, other_errs);
    if (rsp_errs + cnt_errs + other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hw
hw/bus_pkg.sv
hw/addr_decode.sv
hw/req_decode_stage.sv
hw/target_bank_exec.sv
hw/rsp_result_stage.sv
hw/bus_demux_top.sv
testbench/tb_bus_demux.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it, pass or fail comes from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_bus_demux

verilator --binary --timing -f verilog.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
